/* flist.f */
source/audio_pkg.sv
source/scope_pkg.sv
source/wave_capture.sv
source/wave_buffer.sv
source/wave_reader.sv
source/wave_scope_top.sv
tests/wave_scope_tb.sv

/* Makefile */
# Verilator build and run of the wave scope testbench

VERILATOR ?= verilator
TOP       ?= wave_scope_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tests/wave_scope_tb.sv */
`default_nettype none

module wave_scope_tb
    import audio_pkg::*;
    import scope_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_LEN = 1 << FRAME_LOG2;     // Samples per frame
    localparam int TOP_BIT   = SAMPLE_WIDTH - 1;    // Sign bit of a sample

    // One whole frame of display bytes, element k is frame position k
    typedef logic [FRAME_LEN-1:0][DISPLAY_WIDTH-1:0] frame_t;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         sample_ready;
    sample_t      sample_in;
    logic         frame_request;
    display_t     wave_sample;
    frame_index_t wave_index;
    logic         wave_valid;
    logic         frame_ready;

    integer  seed;
    int      cycle_count   = 0;  // Rising edges seen so far
    int      request_cycle = 0;  // Cycle in which the last request was driven
    int      sent_count    = 0;
    int      ready_count   = 0;  // frame_ready pulses seen
    int      frames_read   = 0;  // Complete playbacks seen
    int      out_count     = 0;  // Outputs seen in the current playback
    bit      playing       = 1'b0;
    frame_t  readable_frame;     // Reference for the half the reader may use
    frame_t  expected_frame;     // Reference for the playback in flight
    sample_t log_value[$];       // Every strobed sample in order
    bit      log_flag[$];        // Set while the sample is in the armed window

    wave_scope_top #(
        .FRAME_LOG2   (FRAME_LOG2),
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .DISPLAY_WIDTH(DISPLAY_WIDTH)
    ) i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_ready (sample_ready),
        .sample_in    (sample_in),
        .frame_request(frame_request),
        .wave_sample  (wave_sample),
        .wave_index   (wave_index),
        .wave_valid   (wave_valid),
        .frame_ready  (frame_ready)
    );

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped");
    endtask

    // First rising crossing in the armed window, then the upper bytes of the
    // samples after it; the sign before the window's first sample still counts
    function automatic frame_t reference_frame(output bit found);
        frame_t frame;
        bit     prev_neg;
        int     start;
        frame = '0;
        found = 1'b0;
        start = -1;
        for (int i = 0; i < log_value.size(); i++) begin
            prev_neg = (i == 0) ? 1'b0 : log_value[i-1][TOP_BIT];  // Sign register resets clear
            if (start < 0 && log_flag[i] && prev_neg && !log_value[i][TOP_BIT]) begin
                start = i;
            end
        end
        if (start >= 0 && start + FRAME_LEN < log_value.size()) begin
            for (int k = 0; k < FRAME_LEN; k++) begin
                frame[k] = log_value[start + 1 + k][TOP_BIT -: DISPLAY_WIDTH];
            end
            found = 1'b1;
        end
        return frame;
    endfunction

    function automatic sample_t random_sample(input bit negative);
        sample_t value;
        value = sample_t'($random(seed));
        value[TOP_BIT] = negative;  // Forced sign, the rest stays random
        return value;
    endfunction

    task automatic send_sample(input sample_t value);
        sample_ready = 1'b1;
        sample_in    = value;
        sent_count++;
        @(posedge clk);
        #2;
        sample_ready = 1'b0;
        repeat (3) begin  // One strobe every four cycles
            @(posedge clk);
            #2;
        end
    endtask

    // Random frame contents, the last one non-negative so the next window
    // starts from a known sign
    task automatic send_body(input int count);
        sample_t value;
        for (int i = 0; i < count; i++) begin
            value = sample_t'($random(seed));
            if (i == count - 1) value[TOP_BIT] = 1'b0;
            send_sample(value);
        end
    endtask

    task automatic send_trigger();
        send_sample(random_sample(1'b1));
        send_sample(random_sample(1'b0));  // Rising crossing
    endtask

    task automatic send_alternating(input int count);
        for (int i = 0; i < count; i++) begin
            send_sample(random_sample(i % 2 == 0));
        end
    endtask

    task automatic request_frame();
        expected_frame = readable_frame;  // The half that is readable right now
        request_cycle  = cycle_count;
        playing        = 1'b1;
        frame_request  = 1'b1;
        @(posedge clk);
        #2;
        frame_request = 1'b0;
    endtask

    task automatic wait_ready(input int target, input int limit);
        int waited;
        waited = 0;
        while (ready_count < target && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (ready_count < target) fail_run("timed out waiting for frame_ready");
    endtask

    task automatic wait_playback(input int target, input int limit);
        int waited;
        waited = 0;
        while (frames_read < target && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (frames_read < target) fail_run("timed out waiting for a complete playback");
    endtask

    task automatic wait_sent(input int target, input int limit);
        int waited;
        waited = 0;
        while (sent_count < target && waited < limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (sent_count < target) fail_run("timed out waiting for the sample stream");
    endtask

    // Sample log, output comparison and swap tracking, all on the falling edge
    always @(negedge clk) begin : compare_outputs
        bit found;
        if (arst_n) begin
            if (sample_ready) begin
                log_value.push_back(sample_in);
                log_flag.push_back(1'b1);
            end
            if (wave_valid) begin
                if (!playing) begin
                    fail_run("wave_valid rose without a frame request");
                end else if (out_count >= FRAME_LEN) begin
                    fail_run("wave_valid stayed high past one frame");
                end else begin
                    if (out_count == 0) begin
                        check_value("first valid latency", 2, cycle_count - request_cycle);
                    end
                    check_value("wave_index", out_count, wave_index);
                    check_value("wave_sample", expected_frame[out_count], wave_sample);
                    out_count++;
                end
            end else if (out_count != 0) begin
                check_value("valid run length", FRAME_LEN, out_count);  // No gaps allowed
                out_count   = 0;
                playing     = 1'b0;
                frames_read++;
            end
            if (frame_ready) begin
                if (playing) begin
                    fail_run("frame_ready pulsed while a frame was playing");
                end else begin
                    readable_frame = reference_frame(found);
                    if (!found) begin
                        fail_run("frame_ready without a full frame after a rising crossing");
                    end else begin
                        foreach (log_flag[i]) log_flag[i] = 1'b0;  // New armed window
                        ready_count++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        int base;
        seed          = 67;
        arst_n        = 1'b0;
        sample_ready  = 1'b0;
        sample_in     = '0;
        frame_request = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Only negative samples, so nothing may trigger
        repeat (20) send_sample(random_sample(1'b1));
        check_value("frame_ready count", 0, ready_count);
        check_value("frames played", 0, frames_read);

        // First frame from a rising crossing out of the negative run
        send_sample(random_sample(1'b0));
        send_body(FRAME_LEN);
        wait_ready(1, 2000);
        request_frame();
        wait_playback(1, 600);

        // Falling crossing first, the frame starts at the later rising one
        repeat (3) send_sample(random_sample(1'b0));
        repeat (3) send_sample(random_sample(1'b1));
        check_value("frame_ready count", 1, ready_count);
        send_sample(random_sample(1'b0));
        send_body(FRAME_LEN);
        wait_ready(2, 2000);
        request_frame();
        wait_playback(2, 600);

        // Playback of the old frame spans the end of the next capture
        base = sent_count;
        fork
            begin
                send_trigger();
                send_body(FRAME_LEN);
                send_alternating(25);  // Crossings while held in WAIT, the last one negative
            end
            begin
                wait_sent(base + FRAME_LEN - 14, 2000);
                request_frame();
            end
        join
        wait_playback(3, 600);
        wait_ready(3, 100);
        request_frame();  // Now the newly swapped frame
        wait_playback(4, 600);

        // Two frames back to back, the second written while the first plays
        // The first one crosses against the last sample dropped in WAIT
        send_sample(random_sample(1'b0));
        send_body(FRAME_LEN);
        wait_ready(4, 2000);
        fork
            request_frame();
            begin
                send_trigger();
                send_body(FRAME_LEN);
            end
        join
        wait_playback(5, 600);
        wait_ready(5, 2000);
        request_frame();
        wait_playback(6, 600);
        check_value("frame_ready count", 5, ready_count);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : wave_scope_tb

`default_nettype wire

/* source/wave_scope_top.sv */
`default_nettype none

module wave_scope_top
    import audio_pkg::*;
    import scope_pkg::*;
#(
    parameter int FRAME_LOG2    = scope_pkg::FRAME_LOG2,
    parameter int SAMPLE_WIDTH  = audio_pkg::SAMPLE_WIDTH,
    parameter int DISPLAY_WIDTH = audio_pkg::DISPLAY_WIDTH
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         sample_ready,   // Audio sample strobe
    input  sample_t      sample_in,
    input  logic         frame_request,  // Display asks for one frame
    output display_t     wave_sample,
    output frame_index_t wave_index,
    output logic         wave_valid,
    output logic         frame_ready     // A new frame is readable
);

    // Capture to buffer write port
    buffer_addr_t write_address;
    logic         write_enable;
    display_t     write_sample;

    // Reader to buffer read port
    buffer_addr_t read_address;
    display_t     read_data;

    // Swap link between capture and reader
    logic read_index;
    logic display_idle;

    wave_capture #(
        .FRAME_LOG2   (FRAME_LOG2),
        .SAMPLE_WIDTH (SAMPLE_WIDTH),
        .DISPLAY_WIDTH(DISPLAY_WIDTH)
    ) i_capture (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_ready (sample_ready),
        .sample_in    (sample_in),
        .display_idle (display_idle),
        .write_address(write_address),
        .write_enable (write_enable),
        .write_sample (write_sample),
        .read_index   (read_index),
        .frame_ready  (frame_ready)
    );

    wave_buffer #(
        .FRAME_LOG2   (FRAME_LOG2),
        .DISPLAY_WIDTH(DISPLAY_WIDTH)
    ) i_buffer (
        .clk          (clk),
        .write_enable (write_enable),
        .write_address(write_address),
        .write_sample (write_sample),
        .read_address (read_address),
        .read_data    (read_data)
    );

    wave_reader #(
        .FRAME_LOG2   (FRAME_LOG2),
        .DISPLAY_WIDTH(DISPLAY_WIDTH)
    ) i_reader (
        .clk          (clk),
        .arst_n       (arst_n),
        .frame_request(frame_request),
        .read_index   (read_index),
        .read_data    (read_data),
        .read_address (read_address),
        .display_idle (display_idle),
        .wave_sample  (wave_sample),
        .wave_index   (wave_index),
        .wave_valid   (wave_valid)
    );

endmodule : wave_scope_top

`default_nettype wire

/* source/wave_reader.sv */
`default_nettype none

module wave_reader
    import audio_pkg::*;
    import scope_pkg::*;
#(
    parameter int FRAME_LOG2    = scope_pkg::FRAME_LOG2,
    parameter int DISPLAY_WIDTH = audio_pkg::DISPLAY_WIDTH
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         frame_request,  // One-cycle strobe from the display
    input  logic         read_index,     // Readable half from capture
    input  display_t     read_data,
    output buffer_addr_t read_address,
    output logic         display_idle,
    output display_t     wave_sample,
    output frame_index_t wave_index,
    output logic         wave_valid
);

    localparam frame_index_t LAST_POS = frame_index_t'((1 << FRAME_LOG2) - 1);

    logic         busy;       // Addresses are being issued
    logic         read_half;  // Half latched at acceptance
    frame_index_t pos;        // Address position within the frame
    logic         valid_q;    // Data for the previous address is on read_data
    frame_index_t index_q;
    logic         free;
    logic         accept;

    if (FRAME_LOG2 != scope_pkg::FRAME_LOG2) begin : g_bad_frame
        $error("wave_reader: FRAME_LOG2 differs from scope_pkg");
    end
    if (DISPLAY_WIDTH != $bits(display_t)) begin : g_bad_width
        $error("wave_reader: DISPLAY_WIDTH differs from audio_pkg");
    end

    // Free only once the last sample has left the output stage
    assign free   = !busy && !valid_q;
    assign accept = frame_request && free;

    // A request arriving in the same cycle blocks the swap,
    // otherwise the half latched below could flip under the reader
    assign display_idle = free && !frame_request;

    assign read_address = {read_half, pos};

    // RAM output register already lines up with the delayed valid and index
    assign wave_sample = read_data;
    assign wave_index  = index_q;
    assign wave_valid  = valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            read_half <= 1'b0;
            pos       <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= busy;  // One stage, matches the RAM latency
            if (accept) begin
                busy      <= 1'b1;
                read_half <= read_index;
                pos       <= '0;
            end else if (busy) begin
                pos <= pos + 1'b1;  // Wraps back to zero after the last one
                if (pos == LAST_POS) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Position of the address issued one cycle earlier, next to its data
    always_ff @(posedge clk) begin
        index_q <= pos;
    end

    // Capture must hold the halves while a frame is played
    a_half_stable: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> $stable(read_index));

endmodule : wave_reader

`default_nettype wire

/* source/wave_buffer.sv */
`default_nettype none

module wave_buffer
    import audio_pkg::*;
    import scope_pkg::*;
#(
    parameter int FRAME_LOG2    = scope_pkg::FRAME_LOG2,
    parameter int DISPLAY_WIDTH = audio_pkg::DISPLAY_WIDTH
) (
    input  logic         clk,
    input  logic         write_enable,
    input  buffer_addr_t write_address,
    input  display_t     write_sample,
    input  buffer_addr_t read_address,
    output display_t     read_data      // Valid one cycle after read_address
);

    // Two frames, lower half is frame 0 and upper half is frame 1
    localparam int DEPTH = 2 ** (FRAME_LOG2 + 1);

    logic [DISPLAY_WIDTH-1:0] mem [DEPTH];

    // Port types come from the packages
    if (FRAME_LOG2 != scope_pkg::FRAME_LOG2) begin : g_bad_frame
        $error("wave_buffer: FRAME_LOG2 differs from scope_pkg");
    end
    if (DISPLAY_WIDTH != $bits(display_t)) begin : g_bad_width
        $error("wave_buffer: DISPLAY_WIDTH differs from audio_pkg");
    end

    // Simple dual port, one write and one registered read per cycle
    // Capture and reader never touch the same half, so the read-during-write
    // ordering does not matter here
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_sample;
        end
        read_data <= mem[read_address];  // Maps to block RAM output register
    end

endmodule : wave_buffer

`default_nettype wire

/* source/wave_capture.sv */
`default_nettype none

module wave_capture
    import audio_pkg::*;
    import scope_pkg::*;
#(
    parameter int FRAME_LOG2    = scope_pkg::FRAME_LOG2,
    parameter int SAMPLE_WIDTH  = audio_pkg::SAMPLE_WIDTH,
    parameter int DISPLAY_WIDTH = audio_pkg::DISPLAY_WIDTH
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         sample_ready,  // One-cycle strobe with each sample
    input  sample_t      sample_in,
    input  logic         display_idle,  // Reader is not playing a frame
    output buffer_addr_t write_address,
    output logic         write_enable,
    output display_t     write_sample,
    output logic         read_index,    // Half the reader may use
    output logic         frame_ready    // New frame just became readable
);

    localparam int           SIGN_BIT   = SAMPLE_WIDTH - 1;
    localparam frame_index_t LAST_INDEX = frame_index_t'((1 << FRAME_LOG2) - 1);

    capture_state_t state;
    frame_index_t   count;         // Next slot in the writable half
    logic           prev_sign;     // Sign of the last strobed sample
    logic           new_sign;
    logic           rising_cross;
    logic           frame_done;

    // The typed ports are sized by the packages, so the passed-down
    // geometry has to agree with them
    if (FRAME_LOG2 != scope_pkg::FRAME_LOG2) begin : g_bad_frame
        $error("wave_capture: FRAME_LOG2 differs from scope_pkg");
    end
    if (SAMPLE_WIDTH != $bits(sample_t) || DISPLAY_WIDTH != $bits(display_t)) begin : g_bad_width
        $error("wave_capture: sample or display width differs from audio_pkg");
    end
    if (DISPLAY_WIDTH > SAMPLE_WIDTH) begin : g_bad_slice
        $error("wave_capture: display byte wider than the sample");
    end

    assign new_sign = sample_in[SIGN_BIT];

    // Negative to non-negative between two strobed samples
    assign rising_cross = sample_ready && prev_sign && !new_sign;

    // The write of the last slot closes the frame
    assign frame_done = write_enable && (count == LAST_INDEX);

    // Writes land in the same cycle as the strobe
    assign write_enable  = (state == ACTIVE) && sample_ready;
    assign write_address = {~read_index, count};  // Always the half the reader does not own
    assign write_sample  = sample_in[SIGN_BIT -: DISPLAY_WIDTH];

    // Swap is announced in the WAIT cycle that sees the display idle
    assign frame_ready = (state == WAIT) && display_idle;

    // Sign history is kept in every state, so a crossing right after
    // WAIT is judged against the true previous sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_sign <= 1'b0;
        end else if (sample_ready) begin
            prev_sign <= new_sign;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARMED;
        end else begin
            case (state)
                ARMED: begin
                    if (rising_cross) begin
                        state <= ACTIVE;  // Trigger sample itself is not stored
                    end
                end
                ACTIVE: begin
                    if (frame_done) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (display_idle) begin
                        state <= ARMED;   // Halves swap on this same edge
                    end
                end
                default: state <= ARMED;
            endcase
        end
    end

    // Slot counter, cleared on the trigger and wrapping to zero after the last write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if ((state == ARMED) && rising_cross) begin
            count <= '0;
        end else if (write_enable) begin
            count <= count + 1'b1;
        end
    end

    // Half selector, flipped only when the reader cannot be mid-frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_index <= 1'b0;
        end else if (frame_ready) begin
            read_index <= ~read_index;
        end
    end

    // No slot is written outside a frame, so the counter rests at zero
    // between frames and every frame fills its half from the first slot
    a_count_rests: assert property (@(posedge clk) disable iff (!arst_n)
        (state != ACTIVE) |-> (count == '0));

    // The half under write stays opposite the reader's half for the whole frame
    a_write_half_fixed: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ACTIVE) |-> $stable(read_index));

    // One swap per finished frame, the pulse never stretches
    a_swap_once: assert property (@(posedge clk) disable iff (!arst_n)
        frame_ready |=> !frame_ready);

endmodule : wave_capture

`default_nettype wire

/* source/scope_pkg.sv */
`default_nettype none

// Geometry of the ping-pong trace buffer and the capture FSM encoding
package scope_pkg;

    // Samples per frame as a power of two, 8 gives 256 samples
    localparam int FRAME_LOG2 = 8;

    // Position of a sample within one frame
    typedef logic [FRAME_LOG2-1:0] frame_index_t;

    // Full RAM address
    // The top bit selects the half and the lower bits are the frame index,
    // so one address covers both frames of the ping-pong pair
    typedef logic [FRAME_LOG2:0] buffer_addr_t;

    // Capture FSM states
    // ARMED waits for a rising zero crossing,
    // ACTIVE stores one frame into the writable half,
    // WAIT holds the finished frame until the display side is idle
    typedef enum logic [1:0] {
        ARMED  = 2'b00,
        ACTIVE = 2'b01,
        WAIT   = 2'b10
    } capture_state_t;

endpackage : scope_pkg

`default_nettype wire

/* source/audio_pkg.sv */
`default_nettype none

// Sample format shared by the capture path and the display side
package audio_pkg;

    // Width of one incoming audio sample, two's complement
    localparam int SAMPLE_WIDTH = 16;

    // Width of one stored display byte
    localparam int DISPLAY_WIDTH = 8;

    // One audio sample as it arrives with the strobe
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // The most significant DISPLAY_WIDTH bits of a sample
    // Bit DISPLAY_WIDTH-1 is still the sign of the original sample, so the
    // display side sees a signed byte with the same zero line
    typedef logic [DISPLAY_WIDTH-1:0] display_t;

endpackage : audio_pkg

`default_nettype wire
